// ==== compile.f ====
+incdir+.
vicPkg.sv
vicRasterIf.sv
vicTiming.sv
vicRegs.sv
vicPixelOut.sv
vicTop.sv
vicTb_props.sv
vicTb.sv

// ==== vicPixelOut.sv ====
`timescale 1ns/1ps

module vicPixelOut (
  input  logic          clk25,
  input  logic          rst,
  vicRasterIf.pixel     ras,
  input  vicPkg::colorT borderColor,
  input  vicPkg::colorT bgColor,
  input  logic          den,
  output logic          hSync,
  output logic          vSync,
  output vicPkg::colorT color
);
  import vicPkg::*;

  colorT colorNext;

  // blank first, then border or display off, then background
  always_comb begin
    if (ras.blank)
      colorNext = '0;
    else if (ras.border || !den)
      colorNext = borderColor;
    else
      colorNext = bgColor;
  end

  // ------------------------------
  // output register
  // ------------------------------
  // sync and colour share one stage so they stay lined up
  always_ff @(posedge clk25) begin
    if (rst) begin
      hSync <= 1'b1;
      vSync <= 1'b1;
      color <= '0;
    end else begin
      hSync <= ~ras.hSyncAct;   // active low
      vSync <= ~ras.vSyncAct;
      color <= colorNext;
    end
  end

endmodule

// ==== vicPkg.sv ====
package vicPkg;

  // ------------------------------
  // colour code
  // ------------------------------
  // two bits per channel, red in the top pair
  typedef struct packed {
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } colorT;

  // ------------------------------
  // raster position
  // ------------------------------
  // wide enough for 800 clocks and 525 lines
  typedef logic [11:0] rasterCtrT;

  // ------------------------------
  // register bus
  // ------------------------------
  typedef logic [6:0] regAdrT;  // 128 byte register window

endpackage

// ==== vicRasterIf.sv ====
`timescale 1ns/1ps

interface vicRasterIf;
  import vicPkg::*;

  rasterCtrT hCtr;
  rasterCtrT vCtr;
  logic      lineStart;   // hCtr at 0
  logic      frameStart;  // first clock of a frame
  logic      hSyncAct;
  logic      vSyncAct;
  logic      blank;
  logic      border;

  // counters and region flags come from the timing block
  modport timing (
    output hCtr, vCtr, lineStart, frameStart,
    output hSyncAct, vSyncAct, blank, border
  );

  modport regs (input hCtr, vCtr, lineStart, frameStart);

  modport pixel (input hSyncAct, vSyncAct, blank, border);

endinterface

// ==== vicRegs.sv ====
`timescale 1ns/1ps
`include "vic_settings.svh"

module vicRegs (
  input  logic                   clk25,
  input  logic                   rst,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  vicPkg::regAdrT         wbAdr,
  input  logic [`VIC_DATA_W-1:0] wbDatI,
  output logic [`VIC_DATA_W-1:0] wbDatO,
  output logic                   wbAck,
  output logic                   irq,
  input  logic                   lpN,
  vicRasterIf.regs               ras,
  output vicPkg::colorT          borderColor,
  output vicPkg::colorT          bgColor,
  output logic                   den
);
  import vicPkg::*;

  logic                   access;
  logic                   wrStb;
  logic                   rdStb;
  logic [`VIC_DATA_W-1:0] ctrlReg;
  logic [`VIC_DATA_W-1:0] irqEn;
  rasterCtrT              rasterCmp;
  logic [3:0]             vHiLatch;   // vCtr top bits, caught on RASTER_LO read
  rasterCtrT              lpx;
  rasterCtrT              lpy;
  logic                   irst;       // raster flag
  logic                   ilp;        // light-pen flag
  logic                   rasterDone;
  logic                   lpHit;
  logic                   rasterHit;
  logic                   lpSample;

  // ------------------------------
  // wishbone handshake
  // ------------------------------
  // one ack per access, a held strobe gets an ack every other cycle
  assign access = wbCyc & wbStb & ~wbAck;
  assign wrStb  = access & wbWe;
  assign rdStb  = access & ~wbWe;

  always_ff @(posedge clk25) begin
    if (rst) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= access;
    end
  end

  // ------------------------------
  // write side
  // ------------------------------
  always_ff @(posedge clk25) begin
    if (rst) begin
      ctrlReg     <= 8'h10;  // display enabled
      rasterCmp   <= '0;
      irqEn       <= '0;
      borderColor <= '0;
      bgColor     <= '0;
    end else if (wrStb) begin
      case (wbAdr)
        `VIC_REG_CTRL:      ctrlReg <= wbDatI;
        `VIC_REG_RASTER_LO: rasterCmp[7:0] <= wbDatI;
        `VIC_REG_RASTER_HI: rasterCmp[11:8] <= wbDatI[3:0];
        `VIC_REG_IRQ_EN:    irqEn <= wbDatI;
        `VIC_REG_BORDER:    borderColor <= colorT'(wbDatI[5:0]);
        `VIC_REG_BG:        bgColor <= colorT'(wbDatI[5:0]);
        default: ;
      endcase
    end
  end

  assign den = ctrlReg[4];

  // ------------------------------
  // interrupt sources
  // ------------------------------
  // only one line start per frame can match, the done bit keeps it to one
  assign rasterHit = ras.lineStart && (ras.vCtr == rasterCmp) &&
                     (!rasterDone || ras.frameStart);

  // first low sample of the frame wins
  assign lpSample = !lpN && (!lpHit || ras.frameStart);

  always_ff @(posedge clk25) begin
    if (rst) begin
      irst       <= 1'b0;
      ilp        <= 1'b0;
      rasterDone <= 1'b0;
      lpHit      <= 1'b0;
    end else begin
      if (wrStb && wbAdr == `VIC_REG_IRQ_STAT) begin
        if (wbDatI[0])
          irst <= 1'b0;
        if (wbDatI[3])
          ilp <= 1'b0;
      end
      // a new event beats a clear in the same cycle
      if (rasterHit) begin
        irst       <= 1'b1;
        rasterDone <= 1'b1;
      end else if (ras.frameStart) begin
        rasterDone <= 1'b0;
      end
      if (lpSample) begin
        ilp   <= 1'b1;
        lpHit <= 1'b1;
      end else if (ras.frameStart) begin
        lpHit <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk25) begin
    if (lpSample) begin
      lpx <= ras.hCtr;
      lpy <= ras.vCtr;
    end
  end

  assign irq = (irst & irqEn[0]) | (ilp & irqEn[3]);

  // ------------------------------
  // read side
  // ------------------------------
  always_ff @(posedge clk25) begin
    if (rdStb) begin
      case (wbAdr)
        `VIC_REG_CTRL:      wbDatO <= ctrlReg;
        `VIC_REG_RASTER_LO: begin
          wbDatO   <= ras.vCtr[7:0];
          vHiLatch <= ras.vCtr[11:8];   // keeps the pair coherent
        end
        `VIC_REG_RASTER_HI: wbDatO <= {4'h0, vHiLatch};
        `VIC_REG_LPX_LO:    wbDatO <= lpx[7:0];
        `VIC_REG_LPX_HI:    wbDatO <= {4'h0, lpx[11:8]};
        `VIC_REG_LPY_LO:    wbDatO <= lpy[7:0];
        `VIC_REG_LPY_HI:    wbDatO <= {4'h0, lpy[11:8]};
        `VIC_REG_IRQ_STAT:  wbDatO <= {irq, 3'b111, ilp, 2'b00, irst};
        `VIC_REG_IRQ_EN:    wbDatO <= irqEn;
        `VIC_REG_BORDER:    wbDatO <= {2'b00, borderColor};
        `VIC_REG_BG:        wbDatO <= {2'b00, bgColor};
        default:            wbDatO <= '0;
      endcase
    end
  end

endmodule

// ==== vicTb.sv ====
`timescale 1ns/1ps
`include "vic_settings.svh"

module vicTb;
  import vicPkg::*;

  localparam int LINE  = `VIC_H_TOTAL;
  localparam int FRAME = `VIC_H_TOTAL * `VIC_V_TOTAL;

  logic                   clk25;
  logic                   rst;
  logic                   wbCyc;
  logic                   wbStb;
  logic                   wbWe;
  regAdrT                 wbAdr;
  logic [`VIC_DATA_W-1:0] wbDatI;
  logic [`VIC_DATA_W-1:0] wbDatO;
  logic                   wbAck;
  logic                   lpN;
  logic                   irq;
  logic                   hSync;
  logic                   vSync;
  logic [1:0]             red;
  logic [1:0]             green;
  logic [1:0]             blue;

  int         seed;
  int         n;
  int         nHigh;
  int         penX;
  int         penY;
  int         penXExp;
  int         penYExp;
  logic [7:0] rd;
  logic [7:0] enVal;
  logic [5:0] borderCol;
  logic [5:0] bgCol;

  vicTop i_dut (.*);   // port names match one to one

  always #20 clk25 = ~clk25;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic failNow(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input int exp, input int act);
    assert (exp == act)
      else failNow($sformatf("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act));
  endtask

  // a failed bus or reset property ends the run
  always @(i_dut.uProps.failCnt) begin
    if (i_dut.uProps.failCnt != 0)
      failNow("a bound bus or reset property failed");
  end

  task automatic tick();
    @(posedge clk25);
    #1;   // drive and sample just past the edge
  endtask

  task automatic busCycle(input logic we, input regAdrT adr, input logic [7:0] din,
                          output logic [7:0] dout);
    int t;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatI = din;
    t = 0;
    do begin
      tick();
      t++;
      if (t > 16)
        failNow("timeout, the DUT never acked the wishbone cycle");
    end while (!wbAck);
    dout  = wbDatO;   // valid while ack is high
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic wbWrite(input regAdrT adr, input logic [7:0] din);
    logic [7:0] unused;
    busCycle(1'b1, adr, din, unused);
  endtask

  task automatic wbRead(input regAdrT adr, output logic [7:0] dout);
    busCycle(1'b0, adr, 8'h00, dout);
  endtask

  // 0 hSync, 1 vSync, else irq
  function automatic logic probe(input int sel);
    case (sel)
      0:       return hSync;
      1:       return vSync;
      default: return irq;
    endcase
  endfunction

  task automatic waitLevel(input int sel, input logic level, input int limit,
                           input string what, output int cnt);
    cnt = 0;
    while (probe(sel) !== level) begin
      tick();
      cnt++;
      if (cnt > limit)
        failNow({"timeout, gave up waiting for ", what});
    end
  endtask

  task automatic waitFall(input int sel, input int limit, input string what);
    int cnt;
    waitLevel(sel, 1'b1, limit, what, cnt);
    waitLevel(sel, 1'b0, limit, what, cnt);
  endtask

  // output shows hCtr 16 at the sample of an hSync fall
  task automatic checkColorAt(input int hPos, input int exp, input string name);
    waitFall(0, 2 * LINE, "an hSync fall");
    repeat (hPos - `VIC_H_SYNC_ON) tick();
    checkEq(name, exp, {red, green, blue});
  endtask

  task automatic pulsePen();
    lpN = 1'b0;
    repeat (4) tick();
    lpN = 1'b1;
  endtask

  task automatic readPen(output int x, output int y);
    logic [7:0] lo;
    logic [7:0] hi;
    wbRead(`VIC_REG_LPX_LO, lo);
    wbRead(`VIC_REG_LPX_HI, hi);
    x = {hi[3:0], lo};
    wbRead(`VIC_REG_LPY_LO, lo);
    wbRead(`VIC_REG_LPY_HI, hi);
    y = {hi[3:0], lo};
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    seed   = 61529;
    clk25  = 1'b0;
    rst    = 1'b1;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatI = '0;
    lpN    = 1'b1;
    repeat (10) tick();
    rst = 1'b0;

    checkEq("reset irq", 0, irq);
    checkEq("reset hSync", 1, hSync);
    checkEq("reset vSync", 1, vSync);
    checkEq("reset colour", 0, {red, green, blue});

    // register readback
    borderCol = 6'($random(seed));
    bgCol     = 6'($random(seed));
    enVal     = 8'($random(seed));
    if (bgCol == borderCol)
      bgCol = ~borderCol;   // keep the two regions apart
    wbWrite(`VIC_REG_BORDER, {2'b00, borderCol});
    wbWrite(`VIC_REG_BG, {2'b00, bgCol});
    wbWrite(`VIC_REG_IRQ_EN, enVal);
    wbRead(`VIC_REG_BORDER, rd);
    checkEq("border readback", borderCol, rd);
    wbRead(`VIC_REG_BG, rd);
    checkEq("bg readback", bgCol, rd);
    wbRead(`VIC_REG_IRQ_EN, rd);
    checkEq("irq enable readback", enVal, rd);
    wbWrite(`VIC_REG_IRQ_EN, 8'h00);

    // sync widths
    waitFall(0, 2 * LINE, "an hSync fall");
    waitLevel(0, 1'b1, LINE, "hSync to rise", n);
    waitLevel(0, 1'b0, LINE, "hSync to fall", nHigh);
    checkEq("hSync low width", `VIC_H_SYNC_OFF - `VIC_H_SYNC_ON, n);
    checkEq("hSync period", `VIC_H_TOTAL, n + nHigh);

    waitFall(1, 2 * FRAME, "a vSync fall");
    n = 0;
    while (vSync !== 1'b1) begin
      checkEq("colour in vSync", 0, {red, green, blue});
      tick();
      n++;
      if (n > 4 * LINE)
        failNow("timeout, vSync stayed low too long");
    end
    checkEq("vSync low width", (`VIC_V_SYNC_OFF - `VIC_V_SYNC_ON) * LINE, n);

    // colour regions well inside the vertical window
    repeat (`VIC_V_BORDER_OFF) waitFall(0, 2 * LINE, "an hSync fall");
    checkColorAt(`VIC_H_BORDER_OFF - 8, borderCol, "left border");
    checkColorAt(400, bgCol, "display window");
    checkColorAt(`VIC_H_BORDER_ON + 8, borderCol, "right border");
    wbWrite(`VIC_REG_CTRL, 8'h00);
    checkColorAt(400, borderCol, "display off");
    wbWrite(`VIC_REG_CTRL, 8'h10);

    // raster interrupt
    wbWrite(`VIC_REG_RASTER_LO, 8'd200);
    wbWrite(`VIC_REG_RASTER_HI, 8'h00);
    wbWrite(`VIC_REG_IRQ_STAT, 8'h09);
    wbWrite(`VIC_REG_IRQ_EN, 8'h01);
    waitLevel(2, 1'b1, 2 * FRAME, "the raster irq", n);
    wbRead(`VIC_REG_RASTER_LO, rd);
    checkEq("raster line", 200, rd);
    wbRead(`VIC_REG_IRQ_STAT, rd);
    checkEq("raster flag", 1, rd[0]);
    wbWrite(`VIC_REG_IRQ_STAT, 8'h01);
    checkEq("irq after clear", 0, irq);
    wbWrite(`VIC_REG_IRQ_EN, 8'h00);

    // light pen
    // the counters run one clock ahead of the outputs
    waitFall(1, 2 * FRAME, "a vSync fall");
    repeat (20) waitFall(0, 2 * LINE, "an hSync fall");
    repeat (100) tick();
    pulsePen();
    penXExp = `VIC_H_SYNC_ON + 1 + 100;
    penYExp = `VIC_V_SYNC_ON + 20 - 1;
    readPen(penX, penY);
    checkEq("light pen x", penXExp, penX);
    checkEq("light pen y", penYExp, penY);
    wbRead(`VIC_REG_IRQ_STAT, rd);
    checkEq("light pen flag", 1, rd[3]);
    repeat (2) waitFall(0, 2 * LINE, "an hSync fall");
    pulsePen();   // ignored within the same frame
    readPen(penX, penY);
    checkEq("light pen x held", penXExp, penX);
    checkEq("light pen y held", penYExp, penY);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== vicTb_props.sv ====
`timescale 1ns/1ps
`include "vic_settings.svh"

module vicTb_props (
  input logic clk25,
  input logic rst,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck,
  input logic irq
);

  int failCnt = 0;   // failed assertions so far

  // ------------------------------
  // wishbone handshake
  // ------------------------------
  ackAfterReset: assert property (@(posedge clk25) rst |=> !wbAck)
    else begin
      failCnt++;
      $error("wbAck high in the cycle after reset");
    end

  // ack only answers a live strobe
  ackNeedsStrobe: assert property (@(posedge clk25) disable iff (rst)
    $rose(wbAck) |-> $past(wbCyc && wbStb))
    else begin
      failCnt++;
      $error("wbAck rose without wbCyc and wbStb the cycle before");
    end

  ackOneCycle: assert property (@(posedge clk25) disable iff (rst)
    wbAck |=> !wbAck)
    else begin
      failCnt++;
      $error("wbAck held high for two cycles");
    end

  // ------------------------------
  // interrupt
  // ------------------------------
  // flags come out of reset after the first edge
  irqInReset: assert property (@(posedge clk25) rst ##1 rst |-> !irq)
    else begin
      failCnt++;
      $error("irq high while reset is asserted");
    end

endmodule

bind vicTop vicTb_props uProps (
  .clk25 (clk25),
  .rst   (rst),
  .wbCyc (wbCyc),
  .wbStb (wbStb),
  .wbAck (wbAck),
  .irq   (irq)
);

// ==== vicTiming.sv ====
`timescale 1ns/1ps
`include "vic_settings.svh"

module vicTiming (
  input  logic       clk25,
  input  logic       rst,
  vicRasterIf.timing ras
);
  import vicPkg::*;

  rasterCtrT hCtr;
  rasterCtrT vCtr;
  logic      lineEnd;
  logic      frameEnd;
  logic      hBlank;
  logic      vBlank;
  logic      hBorder;
  logic      vBorder;

  // ------------------------------
  // raster counters
  // ------------------------------
  assign lineEnd  = (hCtr == rasterCtrT'(`VIC_H_TOTAL - 1));
  assign frameEnd = (vCtr == rasterCtrT'(`VIC_V_TOTAL - 1));

  always_ff @(posedge clk25) begin
    if (rst) begin
      hCtr <= '0;
      vCtr <= '0;
    end else if (lineEnd) begin
      hCtr <= '0;
      if (frameEnd)
        vCtr <= '0;
      else
        vCtr <= vCtr + 1'b1;   // next line
    end else begin
      hCtr <= hCtr + 1'b1;
    end
  end

  // ------------------------------
  // regions
  // ------------------------------
  // blank runs from the wrap up to the blank-off point
  assign hBlank  = hCtr < rasterCtrT'(`VIC_H_BLANK_OFF);
  assign vBlank  = vCtr < rasterCtrT'(`VIC_V_BLANK_OFF);
  assign hBorder = (hCtr < rasterCtrT'(`VIC_H_BORDER_OFF)) ||
                   (hCtr >= rasterCtrT'(`VIC_H_BORDER_ON));
  assign vBorder = (vCtr < rasterCtrT'(`VIC_V_BORDER_OFF)) ||
                   (vCtr >= rasterCtrT'(`VIC_V_BORDER_ON));

  assign ras.hCtr       = hCtr;
  assign ras.vCtr       = vCtr;
  assign ras.lineStart  = (hCtr == '0);
  assign ras.frameStart = (hCtr == '0) && (vCtr == '0);
  assign ras.hSyncAct   = (hCtr >= rasterCtrT'(`VIC_H_SYNC_ON)) &&
                          (hCtr < rasterCtrT'(`VIC_H_SYNC_OFF));
  assign ras.vSyncAct   = (vCtr >= rasterCtrT'(`VIC_V_SYNC_ON)) &&
                          (vCtr < rasterCtrT'(`VIC_V_SYNC_OFF));
  assign ras.blank      = hBlank | vBlank;
  assign ras.border     = hBorder | vBorder;   // blank area counts as border too

endmodule

// ==== vicTop.sv ====
`timescale 1ns/1ps
`include "vic_settings.svh"

module vicTop (
  input  logic                   clk25,
  input  logic                   rst,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  vicPkg::regAdrT         wbAdr,
  input  logic [`VIC_DATA_W-1:0] wbDatI,
  output logic [`VIC_DATA_W-1:0] wbDatO,
  output logic                   wbAck,
  input  logic                   lpN,
  output logic                   irq,
  output logic                   hSync,
  output logic                   vSync,
  output logic [1:0]             red,
  output logic [1:0]             green,
  output logic [1:0]             blue
);
  import vicPkg::*;

  colorT borderColor;
  colorT bgColor;
  colorT color;
  logic  den;

  vicRasterIf ras ();

  vicTiming uTiming (
    .clk25 (clk25),
    .rst   (rst),
    .ras   (ras.timing)
  );

  vicRegs uRegs (
    .clk25       (clk25),
    .rst         (rst),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbWe        (wbWe),
    .wbAdr       (wbAdr),
    .wbDatI      (wbDatI),
    .wbDatO      (wbDatO),
    .wbAck       (wbAck),
    .irq         (irq),
    .lpN         (lpN),
    .ras         (ras.regs),
    .borderColor (borderColor),
    .bgColor     (bgColor),
    .den         (den)
  );

  vicPixelOut uPixel (
    .clk25       (clk25),
    .rst         (rst),
    .ras         (ras.pixel),
    .borderColor (borderColor),
    .bgColor     (bgColor),
    .den         (den),
    .hSync       (hSync),
    .vSync       (vSync),
    .color       (color)
  );

  // colour code to the three dac pairs
  assign red   = color.r;
  assign green = color.g;
  assign blue  = color.b;

endmodule

// ==== vic_settings.svh ====
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// ------------------------------
// horizontal timing, in clk25 cycles
// ------------------------------
`define VIC_H_TOTAL      800
`define VIC_H_SYNC_ON    16   // 16 front porch
`define VIC_H_SYNC_OFF   112  // 96 sync
`define VIC_H_BLANK_OFF  160  // 48 back porch
`define VIC_H_BORDER_OFF 176  // 16 left border
`define VIC_H_BORDER_ON  784  // 608 display, then right border

// ------------------------------
// vertical timing, in lines
// ------------------------------
`define VIC_V_TOTAL      525
`define VIC_V_SYNC_ON    10   // 10 front porch
`define VIC_V_SYNC_OFF   12   // 2 sync lines
`define VIC_V_BLANK_OFF  45   // 33 back porch
`define VIC_V_BORDER_OFF 53   // top border
`define VIC_V_BORDER_ON  517  // bottom border to end of frame

// ------------------------------
// register offsets
// ------------------------------
`define VIC_REG_CTRL      7'h5C
`define VIC_REG_RASTER_LO 7'h5E
`define VIC_REG_RASTER_HI 7'h5F
`define VIC_REG_LPX_LO    7'h60
`define VIC_REG_LPX_HI    7'h61
`define VIC_REG_LPY_LO    7'h62
`define VIC_REG_LPY_HI    7'h63
`define VIC_REG_IRQ_STAT  7'h65
`define VIC_REG_IRQ_EN    7'h66
`define VIC_REG_BORDER    7'h67  // exterior colour
`define VIC_REG_BG        7'h68  // background colour

// bus data width
`define VIC_DATA_W 8

`endif
